//--- common/mult_params.svh
`ifndef MULT_PARAMS_SVH
`define MULT_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiplier widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Unsigned operand
`define MULT_OP_W   16

// Full product, twice the operand
`define MULT_PROD_W 32

// Each half of the split final adder
`define MULT_HALF_W 16

// Bits per lookahead group in the low half
`define CLA_GROUP_W 4

`endif

//--- common/mult_pkg.sv
`include "mult_params.svh"

package mult_pkg;

    // Operands and results
    typedef logic [`MULT_OP_W-1:0]   operand_t;
    typedef logic [`MULT_PROD_W-1:0] product_t;
    typedef logic [`MULT_HALF_W-1:0] half_t;

    // Product word, also read as the two halves of the final adder
    typedef union packed {
        product_t word;
        struct packed {
            half_t hi;
            half_t lo;
        } halves;
    } product_u;

endpackage

//--- design/final_adder/cla_adder_16.sv
`include "mult_params.svh"

module cla_adder_16 (
    input  mult_pkg::half_t x,
    input  mult_pkg::half_t y,
    output mult_pkg::half_t sum,
    output logic            cout
);
    import mult_pkg::*;

    localparam int GW = `CLA_GROUP_W;
    localparam int NG = `MULT_HALF_W / `CLA_GROUP_W;

    half_t gen;
    half_t prop;
    half_t carry;
    logic [NG-1:0] grp_gen;
    logic [NG-1:1] grp_prop;
    logic [NG:0]   grp_carry;

    assign gen  = x & y;
    assign prop = x ^ y;

    // Group generate
    always_comb begin
        logic run_p;
        for (int k = 0; k < NG; k++) begin
            grp_gen[k] = 1'b0;
            run_p      = 1'b1;
            for (int m = GW - 1; m >= 0; m--) begin
                grp_gen[k] = grp_gen[k] | (run_p & gen[k*GW + m]);
                run_p      = run_p & prop[k*GW + m];
            end
        end
    end

    // Group propagate, group 0 needs none without a carry in
    for (genvar k = 1; k < NG; k++) begin : g_grp_prop
        assign grp_prop[k] = &prop[k*GW +: GW];
    end

    // Second lookahead level across the groups
    always_comb begin
        logic run_p;
        grp_carry[0] = 1'b0;
        for (int k = 1; k <= NG; k++) begin
            grp_carry[k] = 1'b0;
            run_p        = 1'b1;
            for (int m = k - 1; m >= 0; m--) begin
                grp_carry[k] = grp_carry[k] | (run_p & grp_gen[m]);
                if (m > 0) begin
                    run_p = run_p & grp_prop[m];
                end
            end
        end
    end

    // Bit carries inside each group
    always_comb begin
        logic run_p;
        logic acc;
        for (int k = 0; k < NG; k++) begin
            for (int j = 0; j < GW; j++) begin
                acc   = 1'b0;
                run_p = 1'b1;
                for (int m = j - 1; m >= 0; m--) begin
                    acc   = acc | (run_p & gen[k*GW + m]);
                    run_p = run_p & prop[k*GW + m];
                end
                carry[k*GW + j] = acc | (run_p & grp_carry[k]);
            end
        end
    end

    assign sum  = prop ^ carry;
    assign cout = grp_carry[NG];

endmodule

//--- design/final_adder/final_adder.sv
`include "mult_params.svh"

module final_adder (
    input  logic               clk,
    input  logic               reset,
    input  logic               row_valid,
    input  mult_pkg::product_t sum_row,
    input  mult_pkg::product_t carry_row,
    output logic               out_valid,
    output mult_pkg::product_u product
);
    import mult_pkg::*;

    localparam int HW = `MULT_HALF_W;

    product_u sum_w;
    product_u carry_w;
    half_t    lo_sum;
    half_t    hi_sum;
    logic     lo_cout;
    logic [HW-1:0] hi_c;

    assign sum_w.word   = sum_row;
    assign carry_w.word = carry_row;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Low half, lookahead
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    cla_adder_16 u_cla_adder_16 (
        .x    (sum_w.halves.lo),
        .y    (carry_w.halves.lo),
        .sum  (lo_sum),
        .cout (lo_cout)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // High half, ripple chain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign hi_c[0] = lo_cout;

    for (genvar i = 0; i < HW; i++) begin : g_ripple
        assign hi_sum[i] = sum_w.halves.hi[i] ^ carry_w.halves.hi[i] ^ hi_c[i];

        // Top carry is always zero for an exact 32-bit product
        if (i < HW - 1) begin : g_carry
            assign hi_c[i+1] = (sum_w.halves.hi[i] & carry_w.halves.hi[i])
                             | (sum_w.halves.hi[i] & hi_c[i])
                             | (carry_w.halves.hi[i] & hi_c[i]);
        end
    end

    // Stage 2 register, product holds between strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            product   <= '0;
        end else begin
            out_valid <= row_valid;
            if (row_valid) begin
                product.halves.hi <= hi_sum;
                product.halves.lo <= lo_sum;
            end
        end
    end

endmodule

//--- design/mult_top.sv
module mult_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  mult_pkg::operand_t a,
    input  mult_pkg::operand_t b,
    output logic               out_valid,
    output mult_pkg::product_u product
);
    import mult_pkg::*;

    // Carry-save rows between the two pipeline stages
    product_t sum_row;
    product_t carry_row;
    logic     row_valid;

    // Stage 1
    pp_reduce_tree u_pp_reduce_tree (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .sum_row   (sum_row),
        .carry_row (carry_row),
        .row_valid (row_valid)
    );

    // Stage 2
    final_adder u_final_adder (
        .clk       (clk),
        .reset     (reset),
        .row_valid (row_valid),
        .sum_row   (sum_row),
        .carry_row (carry_row),
        .out_valid (out_valid),
        .product   (product)
    );

endmodule

//--- design/reduce_tree/compressor_4_2.sv
module compressor_4_2 (
    input  logic x0,
    input  logic x1,
    input  logic x2,
    input  logic x3,
    input  logic cin,
    output logic sum,
    output logic carry,
    output logic cout
);

    logic s1;

    // First full adder over x0..x2, cout never sees cin
    assign s1   = x0 ^ x1 ^ x2;
    assign cout = (x0 & x1) | (x0 & x2) | (x1 & x2);

    // Second full adder
    assign sum   = s1 ^ x3 ^ cin;
    assign carry = (s1 & x3) | (s1 & cin) | (x3 & cin);

endmodule

//--- design/reduce_tree/pp_reduce_tree.sv
`include "mult_params.svh"

module pp_reduce_tree (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  mult_pkg::operand_t a,
    input  mult_pkg::operand_t b,
    output mult_pkg::product_t sum_row,
    output mult_pkg::product_t carry_row,
    output logic               row_valid
);
    import mult_pkg::*;

    localparam int OP_W   = `MULT_OP_W;
    localparam int PROD_W = `MULT_PROD_W;

    // Rows halve at each level 16 8 4 2
    localparam int LEVELS = $clog2(OP_W) - 1;

    // All rows of all levels, level L starts at 2*OP_W - (2*OP_W >> L)
    localparam int N_ROWS = 2 * OP_W - 2;
    localparam int LAST   = N_ROWS - 2;

    product_t tree_rows [N_ROWS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Partial products
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Row j is a & b[j], placed in columns j to j+15
    for (genvar j = 0; j < OP_W; j++) begin : g_pp_row
        assign tree_rows[j] = product_t'(a & {OP_W{b[j]}}) << j;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compression levels
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        localparam int SRC   = 2 * OP_W - ((2 * OP_W) >> lvl);
        localparam int DST   = 2 * OP_W - ((2 * OP_W) >> (lvl + 1));
        localparam int N_GRP = OP_W >> (lvl + 2);

        // Four rows in, two rows out per group
        for (genvar grp = 0; grp < N_GRP; grp++) begin : g_group
            product_t sum_v;
            product_t carry_v;
            product_t cout_v;
            product_t cin_v;

            // cout of each column feeds the compressor one column up
            assign cin_v = {cout_v[PROD_W-2:0], 1'b0};

            for (genvar col = 0; col < PROD_W; col++) begin : g_col
                compressor_4_2 u_comp (
                    .x0    (tree_rows[SRC + 4*grp][col]),
                    .x1    (tree_rows[SRC + 4*grp + 1][col]),
                    .x2    (tree_rows[SRC + 4*grp + 2][col]),
                    .x3    (tree_rows[SRC + 4*grp + 3][col]),
                    .cin   (cin_v[col]),
                    .sum   (sum_v[col]),
                    .carry (carry_v[col]),
                    .cout  (cout_v[col])
                );
            end

            // Nothing leaves column 31 since every group sum fits 32 bits
            assign tree_rows[DST + 2*grp]     = sum_v;
            assign tree_rows[DST + 2*grp + 1] = {carry_v[PROD_W-2:0], 1'b0};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 1 register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_row   <= '0;
            carry_row <= '0;
            row_valid <= 1'b0;
        end else begin
            row_valid <= in_valid;
            if (in_valid) begin
                sum_row   <= tree_rows[LAST];
                carry_row <= tree_rows[LAST + 1];
            end
        end
    end

endmodule

//--- dv/mult_props.sv
module mult_props (
    input logic               clk,
    input logic               reset,
    input logic               in_valid,
    input logic               out_valid,
    input mult_pkg::product_u product
);
    timeunit 1ns;
    timeprecision 100ps;

    import mult_pkg::*;

    // Output stage is cleared by reset
    assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // Two register stages, no stalls
    assert property (@(posedge clk) disable iff (reset) out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two cycles");

    assert property (@(posedge clk) disable iff (reset) out_valid |-> !$isunknown(product))
        else $error("product has unknown bits while out_valid is high");

endmodule

bind mult_top mult_props u_mult_props (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .product   (product)
);

//--- dv/mult_tb.sv
`include "mult_params.svh"

module mult_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mult_pkg::*;

    localparam int TIMEOUT_CYCLES = 1000;

    logic     clk = 1'b0;
    logic     reset;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_u product;

    product_t expected_q [$];
    string    test_name = "none";
    bit       check_halves = 1'b0;
    int       mismatch_count = 0;
    int       other_count = 0;
    int       cycle_count = 0;
    logic     iv_d1 = 1'b0;
    logic     iv_d2 = 1'b0;
    product_t last_word = '0;

    mult_top u_mult_top (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .product   (product)
    );

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_product(input string name, input product_t exp, input product_t act);
        if (exp !== act) begin
            $display("MISMATCH test=%s expected=%h actual=%h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_half(input string name, input half_t exp, input half_t act);
        if (exp !== act) begin
            $display("MISMATCH test=%s half expected=%h actual=%h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH test=%s out_valid expected=%b actual=%b", name, exp, act);
            mismatch_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scoreboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Record accepted pairs where the DUT samples them
    always @(posedge clk) begin
        if (reset) begin
            iv_d1 = 1'b0;
            iv_d2 = 1'b0;
        end else begin
            iv_d2 = iv_d1;
            iv_d1 = in_valid;
            if (in_valid) begin
                expected_q.push_back(product_t'(a) * product_t'(b));
            end
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        product_t exp;
        check_valid(test_name, iv_d2, out_valid);
        if (out_valid) begin
            if (expected_q.size() == 0) begin
                $display("ERROR: test %s saw out_valid with no product outstanding", test_name);
                other_count++;
            end else begin
                exp = expected_q.pop_front();
                check_product(test_name, exp, product.word);
                if (check_halves) begin
                    check_half(test_name, exp[31:16], product.halves.hi);
                    check_half(test_name, exp[15:0], product.halves.lo);
                end
            end
            last_word = product.word;
        end else begin
            // Product must hold between strobes
            check_product(test_name, last_word, product.word);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_pair(input operand_t op_a, input operand_t op_b);
        @(negedge clk);
        in_valid = 1'b1;
        a = op_a;
        b = op_b;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Wait until every pair in flight has come out
    task automatic drain_pipeline();
        drive_idle();
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset();
        test_name = "reset";
        repeat (4) begin
            @(negedge clk);
            check_valid(test_name, 1'b0, out_valid);
            check_product(test_name, '0, product.word);
        end
        reset = 1'b0;
        @(negedge clk);
        check_valid(test_name, 1'b0, out_valid);
        check_product(test_name, '0, product.word);
    endtask

    task automatic test_corners();
        test_name = "corners";
        drive_pair(16'h0000, 16'hffff);
        drive_pair(16'h0001, operand_t'($urandom));
        drive_pair(operand_t'($urandom), 16'h0001);
        drive_pair(16'hffff, 16'hffff);
        for (int i = 0; i < `MULT_OP_W; i++) begin
            drive_pair(operand_t'(1) << i, 16'hffff);
        end
        drain_pipeline();
    endtask

    task automatic test_stream();
        test_name = "stream";
        repeat (200) begin
            drive_pair(operand_t'($urandom), operand_t'($urandom));
        end
        drain_pipeline();
    endtask

    task automatic test_gapped();
        int gap;
        test_name = "gapped";
        repeat (60) begin
            drive_pair(operand_t'($urandom), operand_t'($urandom));
            gap = $urandom % 4;
            repeat (gap) drive_idle();
        end
        drain_pipeline();
    endtask

    task automatic test_carry();
        test_name = "carry_halves";
        check_halves = 1'b1;
        drive_pair(16'h00ff, 16'h0101);
        drive_pair(16'h8001, 16'h7fff);
        drive_pair(16'hffff, 16'h0003);
        drive_pair(16'h00ff, 16'h00ff);
        drain_pipeline();
        check_halves = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        void'($urandom(22));

        test_reset();
        test_corners();
        test_stream();
        test_gapped();
        test_carry();

        if (expected_q.size() != 0) begin
            $display("ERROR: %0d products never came out", expected_q.size());
            other_count++;
        end

        $display("Errors: %0d mismatches, %0d other, %0d total",
                 mismatch_count, other_count, mismatch_count + other_count);
        if (mismatch_count + other_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+common
common/mult_pkg.sv
design/reduce_tree/compressor_4_2.sv
design/reduce_tree/pp_reduce_tree.sv
design/final_adder/cla_adder_16.sv
design/final_adder/final_adder.sv
design/mult_top.sv
dv/mult_props.sv
dv/mult_tb.sv
